/* include/loader_consts.svh */
`ifndef LOADER_CONSTS_SVH
`define LOADER_CONSTS_SVH

// clk_osc cycles per sd_clk half period, keep it even
`define SD_CLK_DIV 4

// idle sd_clk pulses with cs high before CMD0
`define SD_INIT_CLOCKS 80

// payload bytes per sector
`define SECTOR_BYTES 512

// first sector holding model parameters
`define START_SECTOR 16

// sectors loaded in one run
`define SECTOR_COUNT 2

// memory app port word and address width
`define APP_DATA_WIDTH 128
`define APP_ADDR_WIDTH 28

// first app address written
`define APP_BASE_ADDR 0

// address increase per 128-bit word
`define APP_ADDR_STEP 8

`endif

/* hw/sd_pkg.sv */
package sd_pkg;

	// command indices used by the loader
	typedef enum logic [5:0] {
		GO_IDLE         = 6'd0,
		READ_SINGLE     = 6'd17,
		SD_SEND_OP_COND = 6'd41,
		APP_CMD         = 6'd55
	} sd_cmd_e;

	// card controller states, in sequence order
	typedef enum logic [3:0] {
		WAIT_CALIB,
		INIT_CLOCKS,
		SEND_CMD,
		GET_R1,
		WAIT_TOKEN,
		READ_DATA,
		SKIP_CRC,
		NEXT,
		DONE
	} sd_state_e;

	// one payload byte per valid cycle
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} sd_byte_t;

endpackage

/* hw/mem_pkg.sv */
`include "loader_consts.svh"

package mem_pkg;

	// app write request
	// en held until app_rdy and app_wdf_rdy meet
	typedef struct packed {
		logic                       en;
		logic [`APP_ADDR_WIDTH-1:0] addr;
		logic [`APP_DATA_WIDTH-1:0] data;
	} app_wr_t;

	// packer states
	// FILL collects bytes, WRITE offers the word
	typedef enum logic {
		FILL,
		WRITE
	} pack_state_e;

endpackage

/* hw/sd_spi_byte.sv */
`include "loader_consts.svh"

module sd_spi_byte (
	input  logic       clk_osc,
	input  logic       arst_n,
	input  logic       xfer_start,
	input  logic [7:0] tx_byte,
	input  logic       cs_level,
	input  logic       sd_miso,
	output logic       xfer_done,
	output logic [7:0] rx_byte,
	output logic       sd_clk,
	output logic       sd_cs,
	output logic       sd_mosi
);

	localparam int DIV_W = $clog2(`SD_CLK_DIV);

	logic             busy;
	logic [DIV_W-1:0] div_cnt;
	// counts sd_clk edges, 16 per byte
	logic [3:0]       edge_cnt;
	logic [7:0]       tx_shift;
	logic             half_tick;

	// end of one sd_clk half period
	assign half_tick = busy && (div_cnt == DIV_W'(`SD_CLK_DIV - 1));
	// last falling edge closes the byte
	assign xfer_done = half_tick && (edge_cnt == 4'd15);

	// mode 0, msb already on the line before the first rising edge
	assign sd_mosi = tx_shift[7];
	assign sd_cs = cs_level;

	always_ff @(posedge clk_osc or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			div_cnt <= '0;
			edge_cnt <= '0;
			sd_clk <= 1'b0;
			// idle line high
			tx_shift <= 8'hff;
		end else if (xfer_start) begin
			busy <= 1'b1;
			div_cnt <= '0;
			edge_cnt <= '0;
			tx_shift <= tx_byte;
		end else if (busy) begin
			if (half_tick) begin
				div_cnt <= '0;
				edge_cnt <= edge_cnt + 4'd1;
				sd_clk <= ~sd_clk;
				// falling edge, next bit out
				// ones shifted in leave mosi high afterwards
				if (sd_clk) begin
					tx_shift <= {tx_shift[6:0], 1'b1};
				end
				if (edge_cnt == 4'd15) begin
					busy <= 1'b0;
				end
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// sample miso on rising edges, msb first
	always_ff @(posedge clk_osc) begin
		if (half_tick && !sd_clk) begin
			rx_byte <= {rx_byte[6:0], sd_miso};
		end
	end

endmodule

/* hw/sd_card_ctrl.sv */
`include "loader_consts.svh"

module sd_card_ctrl (
	input  logic            clk_osc,
	input  logic            arst_n,
	input  logic            init_calib_complete,
	input  logic            xfer_done,
	input  logic [7:0]      rx_byte,
	input  logic            byte_space,
	output logic            xfer_start,
	output logic [7:0]      tx_byte,
	output logic            cs_level,
	output sd_pkg::sd_byte_t payload,
	output logic            card_ready,
	output logic            load_done
);

	localparam int CNT_W = $clog2(`SECTOR_BYTES);
	localparam int SEC_W = $clog2(`SECTOR_COUNT + 1);
	// idle clocks go out as whole 0xff bytes
	localparam int INIT_XFERS = `SD_INIT_CLOCKS / 8;

	sd_pkg::sd_state_e state;
	sd_pkg::sd_cmd_e   cur_cmd;
	logic [31:0]       cmd_arg;
	logic [CNT_W-1:0]  cnt;
	logic [SEC_W-1:0]  sector_idx;
	// a byte is on the wire
	logic              pending;
	logic              want_xfer;
	logic [7:0]        next_tx;

	// 0x40 | index, arg msb first, crc byte
	function automatic logic [7:0] frame_byte(
		input sd_pkg::sd_cmd_e cmd,
		input logic [31:0]     arg,
		input logic [2:0]      idx
	);
		case (idx)
			3'd0: frame_byte = {2'b01, cmd};
			3'd1: frame_byte = arg[31:24];
			3'd2: frame_byte = arg[23:16];
			3'd3: frame_byte = arg[15:8];
			3'd4: frame_byte = arg[7:0];
			// only CMD0 needs a valid crc in spi mode
			default: frame_byte = (cmd == sd_pkg::GO_IDLE) ? 8'h95 : 8'h01;
		endcase
	endfunction

	// which byte the current state wants to move
	always_comb begin
		want_xfer = 1'b0;
		next_tx = 8'hff;
		case (state)
			sd_pkg::INIT_CLOCKS, sd_pkg::GET_R1, sd_pkg::WAIT_TOKEN,
			sd_pkg::SKIP_CRC, sd_pkg::NEXT: begin
				want_xfer = 1'b1;
			end
			sd_pkg::SEND_CMD: begin
				want_xfer = 1'b1;
				next_tx = frame_byte(cur_cmd, cmd_arg, cnt[2:0]);
			end
			// payload waits for room in the packer
			sd_pkg::READ_DATA: want_xfer = byte_space;
			default: want_xfer = 1'b0;
		endcase
	end

	// data bytes go straight out with the done strobe
	assign payload.valid = (state == sd_pkg::READ_DATA) && xfer_done;
	assign payload.data = rx_byte;

	always_ff @(posedge clk_osc or negedge arst_n) begin
		if (!arst_n) begin
			state <= sd_pkg::WAIT_CALIB;
			cur_cmd <= sd_pkg::GO_IDLE;
			cmd_arg <= '0;
			cnt <= '0;
			sector_idx <= '0;
			pending <= 1'b0;
			xfer_start <= 1'b0;
			tx_byte <= 8'hff;
			cs_level <= 1'b1;
			card_ready <= 1'b0;
			load_done <= 1'b0;
		end else begin
			xfer_start <= 1'b0;
			if (want_xfer && !pending) begin
				xfer_start <= 1'b1;
				tx_byte <= next_tx;
				pending <= 1'b1;
			end
			if (xfer_done) begin
				pending <= 1'b0;
			end

			case (state)
				sd_pkg::WAIT_CALIB: begin
					if (init_calib_complete) begin
						state <= sd_pkg::INIT_CLOCKS;
					end
				end
				sd_pkg::INIT_CLOCKS: begin
					if (xfer_done) begin
						if (cnt == CNT_W'(INIT_XFERS - 1)) begin
							cnt <= '0;
							cs_level <= 1'b0;
							state <= sd_pkg::SEND_CMD;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				// six frame bytes
				sd_pkg::SEND_CMD: begin
					if (xfer_done) begin
						if (cnt == CNT_W'(5)) begin
							cnt <= '0;
							state <= sd_pkg::GET_R1;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				// poll until the card drives something other than 0xff
				sd_pkg::GET_R1: begin
					if (xfer_done && rx_byte != 8'hff) begin
						state <= sd_pkg::NEXT;
						cs_level <= 1'b1;
						case (cur_cmd)
							sd_pkg::GO_IDLE: begin
								cur_cmd <= sd_pkg::APP_CMD;
								cmd_arg <= '0;
							end
							sd_pkg::APP_CMD: begin
								cur_cmd <= sd_pkg::SD_SEND_OP_COND;
								// HCS set, high capacity accepted
								cmd_arg <= 32'h4000_0000;
							end
							sd_pkg::SD_SEND_OP_COND: begin
								if (rx_byte == 8'h00) begin
									card_ready <= 1'b1;
									cur_cmd <= sd_pkg::READ_SINGLE;
									cmd_arg <= 32'(`START_SECTOR);
								end else begin
									// still idle, next CMD55 + ACMD41 pair
									cur_cmd <= sd_pkg::APP_CMD;
									cmd_arg <= '0;
								end
							end
							default: begin
								// CMD17 keeps cs low into the data phase
								cs_level <= 1'b0;
								state <= sd_pkg::WAIT_TOKEN;
							end
						endcase
					end
				end
				sd_pkg::WAIT_TOKEN: begin
					if (xfer_done && rx_byte == 8'hfe) begin
						cnt <= '0;
						state <= sd_pkg::READ_DATA;
					end
				end
				sd_pkg::READ_DATA: begin
					if (xfer_done) begin
						if (cnt == CNT_W'(`SECTOR_BYTES - 1)) begin
							cnt <= '0;
							state <= sd_pkg::SKIP_CRC;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				// two crc bytes, dropped
				sd_pkg::SKIP_CRC: begin
					if (xfer_done) begin
						if (cnt == CNT_W'(1)) begin
							cnt <= '0;
							sector_idx <= sector_idx + 1'b1;
							cmd_arg <= cmd_arg + 32'd1;
							cs_level <= 1'b1;
							state <= sd_pkg::NEXT;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				// one gap byte with cs high between commands
				sd_pkg::NEXT: begin
					if (xfer_done) begin
						if (sector_idx == SEC_W'(`SECTOR_COUNT)) begin
							state <= sd_pkg::DONE;
						end else begin
							cnt <= '0;
							cs_level <= 1'b0;
							state <= sd_pkg::SEND_CMD;
						end
					end
				end
				// last word has left the packer once it has room again
				default: begin
					if (byte_space) begin
						load_done <= 1'b1;
					end
				end
			endcase
		end
	end

endmodule

/* hw/app_write_packer.sv */
`include "loader_consts.svh"

module app_write_packer (
	input  logic             clk_osc,
	input  logic             arst_n,
	input  sd_pkg::sd_byte_t payload,
	input  logic             app_rdy,
	input  logic             app_wdf_rdy,
	output logic             byte_space,
	output mem_pkg::app_wr_t app_wr
);

	localparam int BYTES_PER_WORD = `APP_DATA_WIDTH / 8;
	localparam int BW = $clog2(BYTES_PER_WORD);

	mem_pkg::pack_state_e       state;
	logic [BW-1:0]              byte_cnt;
	logic [`APP_ADDR_WIDTH-1:0] addr_q;
	logic [`APP_DATA_WIDTH-1:0] word_q;
	// command and data accepted together
	logic                       accept;

	assign accept = app_rdy && app_wdf_rdy;
	assign byte_space = (state == mem_pkg::FILL);

	assign app_wr.en = (state == mem_pkg::WRITE);
	assign app_wr.addr = addr_q;
	assign app_wr.data = word_q;

	always_ff @(posedge clk_osc or negedge arst_n) begin
		if (!arst_n) begin
			state <= mem_pkg::FILL;
			byte_cnt <= '0;
			addr_q <= `APP_ADDR_WIDTH'(`APP_BASE_ADDR);
		end else begin
			case (state)
				mem_pkg::FILL: begin
					if (payload.valid) begin
						byte_cnt <= byte_cnt + 1'b1;
						// 16th byte completes the word
						if (byte_cnt == BW'(BYTES_PER_WORD - 1)) begin
							state <= mem_pkg::WRITE;
						end
					end
				end
				default: begin
					// word and address held until accepted
					if (accept) begin
						addr_q <= addr_q + `APP_ADDR_WIDTH'(`APP_ADDR_STEP);
						state <= mem_pkg::FILL;
					end
				end
			endcase
		end
	end

	// little endian, byte k lands in bits 8k+7 to 8k
	always_ff @(posedge clk_osc) begin
		if (byte_space && payload.valid) begin
			word_q[{byte_cnt, 3'b000} +: 8] <= payload.data;
		end
	end

endmodule

/* hw/model_loader_top.sv */
module model_loader_top (
	input  logic             clk_osc,
	input  logic             arst_n,
	input  logic             init_calib_complete,
	input  logic             app_rdy,
	input  logic             app_wdf_rdy,
	input  logic             sd_miso,
	output mem_pkg::app_wr_t app_wr,
	output logic             sd_clk,
	output logic             sd_cs,
	output logic             sd_mosi,
	output logic [1:0]       led
);

	// controller to spi engine
	logic             xfer_start;
	logic             xfer_done;
	logic [7:0]       tx_byte;
	logic [7:0]       rx_byte;
	logic             cs_level;
	// payload stream into the packer
	sd_pkg::sd_byte_t payload;
	logic             byte_space;
	// status
	logic             card_ready;
	logic             load_done;

	// led[0] card ready, led[1] load done
	assign led = {load_done, card_ready};

	sd_card_ctrl sd_card_ctrl_inst (
		.clk_osc             (clk_osc),
		.arst_n              (arst_n),
		.init_calib_complete (init_calib_complete),
		.xfer_done           (xfer_done),
		.rx_byte             (rx_byte),
		.byte_space          (byte_space),
		.xfer_start          (xfer_start),
		.tx_byte             (tx_byte),
		.cs_level            (cs_level),
		.payload             (payload),
		.card_ready          (card_ready),
		.load_done           (load_done)
	);

	sd_spi_byte sd_spi_byte_inst (
		.clk_osc    (clk_osc),
		.arst_n     (arst_n),
		.xfer_start (xfer_start),
		.tx_byte    (tx_byte),
		.cs_level   (cs_level),
		.sd_miso    (sd_miso),
		.xfer_done  (xfer_done),
		.rx_byte    (rx_byte),
		.sd_clk     (sd_clk),
		.sd_cs      (sd_cs),
		.sd_mosi    (sd_mosi)
	);

	app_write_packer app_write_packer_inst (
		.clk_osc     (clk_osc),
		.arst_n      (arst_n),
		.payload     (payload),
		.app_rdy     (app_rdy),
		.app_wdf_rdy (app_wdf_rdy),
		.byte_space  (byte_space),
		.app_wr      (app_wr)
	);

endmodule

/* verification/tb_clock_gen.sv */
module tb_clock_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic arst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk = ~clk;
		end
	end

	// reset held low for a fixed number of rising edges
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

/* verification/sd_card_model.sv */
`include "loader_consts.svh"

module sd_card_model (
	input  logic sd_clk,
	input  logic sd_cs,
	input  logic sd_mosi,
	output logic sd_miso,
	output int   errors,
	output logic init_ok,
	output int   reads_done
);

	timeunit 1ns;
	timeprecision 1ps;

	// sector contents filled when each CMD17 arrives
	logic [7:0] sector_mem [`SECTOR_COUNT * `SECTOR_BYTES];
	// bytes waiting to go out on miso
	logic [7:0] out_q [$];
	logic [7:0] frame [6];
	logic [7:0] rx_shift;
	logic [7:0] tx_cur;
	logic       miso_q;
	int         bit_cnt;
	int         frame_len;
	int         idle_clocks;
	int         busy_left;
	bit         seen_cmd0;
	bit         expect_none;
	int         expect_cmd;

	// miso floats high while deselected
	assign sd_miso = (sd_cs === 1'b0) ? miso_q : 1'b1;

	initial begin
		errors = 0;
		init_ok = 1'b0;
		reads_done = 0;
		tx_cur = 8'hff;
		miso_q = 1'b1;
		rx_shift = 8'hff;
		bit_cnt = 0;
		frame_len = 0;
		idle_clocks = 0;
		busy_left = 0;
		seen_cmd0 = 1'b0;
		expect_none = 1'b0;
		expect_cmd = 0;
	end

	// 0 to 3 filler bytes before a response
	task automatic push_gap();
		int n;
		n = $urandom_range(0, 3);
		repeat (n) out_q.push_back(8'hff);
	endtask

	task automatic run_command();
		logic [5:0]  idx;
		logic [31:0] arg;
		logic [7:0]  crc;
		int          base;
		idx = frame[0][5:0];
		arg = {frame[1], frame[2], frame[3], frame[4]};
		crc = (idx == 6'd0) ? 8'h95 : 8'h01;
		assert (frame[5] == crc) else begin
			$display("Error frame crc cmd%0d: expected %h, actual %h", idx, crc, frame[5]);
			errors++;
		end
		assert (!expect_none) else begin
			$display("card received cmd%0d after the last sector was read", idx);
			errors++;
		end
		assert (int'(idx) == expect_cmd) else begin
			$display("Error command order: expected cmd%0d, actual cmd%0d", expect_cmd, idx);
			errors++;
		end
		push_gap();
		case (idx)
			6'd0: begin
				assert (idle_clocks >= `SD_INIT_CLOCKS) else begin
					$display("Error init clocks: expected >= %0d, actual %0d",
						`SD_INIT_CLOCKS, idle_clocks);
					errors++;
				end
				seen_cmd0 = 1'b1;
				busy_left = $urandom_range(1, 3);
				out_q.push_back(8'h01);
				expect_cmd = 55;
			end
			6'd55: begin
				out_q.push_back(init_ok ? 8'h00 : 8'h01);
				expect_cmd = 41;
			end
			6'd41: begin
				if (busy_left > 0) begin
					busy_left--;
					out_q.push_back(8'h01);
					expect_cmd = 55;
				end else begin
					init_ok = 1'b1;
					out_q.push_back(8'h00);
					expect_cmd = 17;
				end
			end
			6'd17: begin
				assert (arg == 32'(`START_SECTOR + reads_done)) else begin
					$display("Error sector argument: expected %0d, actual %0d",
						`START_SECTOR + reads_done, arg);
					errors++;
				end
				if (reads_done < `SECTOR_COUNT) begin
					base = reads_done * `SECTOR_BYTES;
					out_q.push_back(8'h00);
					push_gap();
					// start token, payload, then two crc bytes
					out_q.push_back(8'hfe);
					for (int i = 0; i < `SECTOR_BYTES; i++) begin
						sector_mem[base + i] = 8'($urandom);
						out_q.push_back(sector_mem[base + i]);
					end
					out_q.push_back(8'($urandom));
					out_q.push_back(8'($urandom));
					reads_done++;
					expect_none = (reads_done == `SECTOR_COUNT);
				end
			end
			// illegal command bit
			default: out_q.push_back(8'h04);
		endcase
	endtask

	task automatic take_byte(input logic [7:0] b);
		if (frame_len == 0 && b[7:6] == 2'b01) begin
			frame[0] = b;
			frame_len = 1;
		end else if (frame_len > 0) begin
			frame[frame_len] = b;
			frame_len++;
			if (frame_len == 6) begin
				frame_len = 0;
				run_command();
			end
		end
	endtask

	// card samples mosi on rising edges
	always @(posedge sd_clk) begin
		if (sd_cs === 1'b1) begin
			if (!seen_cmd0) begin
				idle_clocks++;
			end
		end else if (sd_cs === 1'b0) begin
			rx_shift = {rx_shift[6:0], sd_mosi};
			bit_cnt++;
		end
	end

	// and shifts miso on falling edges
	// the eighth falling edge closes a byte even when cs rises with it
	always @(negedge sd_clk) begin
		if (bit_cnt == 8) begin
			bit_cnt = 0;
			take_byte(rx_shift);
			if (out_q.size() > 0) begin
				tx_cur = out_q.pop_front();
			end else begin
				tx_cur = 8'hff;
			end
			miso_q = tx_cur[7];
		end else if (sd_cs === 1'b0) begin
			miso_q = tx_cur[7 - bit_cnt];
		end
	end

endmodule

/* verification/tb_model_loader.sv */
`include "loader_consts.svh"

module tb_model_loader;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int SEED = 90533;
	localparam int CLK_PERIOD = 100;
	// percent of cycles that each ready is low
	localparam int STALL_PCT = 30;
	localparam int BPW = `APP_DATA_WIDTH / 8;
	localparam int WORDS = `SECTOR_COUNT * `SECTOR_BYTES / BPW;
	// one spi byte plus start and done overhead
	localparam int BYTE_CYCLES = 16 * `SD_CLK_DIV + 4;
	// payload plus frames, gaps, tokens, crc and init bytes
	localparam int SD_BYTES = `SECTOR_COUNT * (`SECTOR_BYTES + 40) + 200;
	// chance that both readies are high together
	localparam int ACCEPT_PCT = (100 - STALL_PCT) * (100 - STALL_PCT) / 100;
	localparam int STALL_CYCLES = WORDS * 40 * 100 / ACCEPT_PCT;
	localparam int CALIB_MAX = 60;
	localparam int QUIET_CYCLES = 300;
	localparam int LIMIT_CYCLES =
		2 * (SD_BYTES * BYTE_CYCLES + STALL_CYCLES + CALIB_MAX + 8) + QUIET_CYCLES;

	logic             clk_osc;
	logic             arst_n;
	logic             init_calib_complete;
	logic             app_rdy;
	logic             app_wdf_rdy;
	logic             sd_miso;
	logic             sd_clk;
	logic             sd_cs;
	logic             sd_mosi;
	logic [1:0]       led;
	mem_pkg::app_wr_t app_wr;
	// last offered request that was not accepted
	mem_pkg::app_wr_t held;
	logic             hold_pending;
	logic             done_seen;
	int               words_seen;
	int               gate_errors;
	int               write_errors;
	int               end_errors;
	int               card_errors;
	logic             card_init_ok;
	int               card_reads;

	tb_clock_gen #(
		.PERIOD_NS    (CLK_PERIOD),
		.RESET_CYCLES (8)
	) tb_clock_gen_inst (
		.clk    (clk_osc),
		.arst_n (arst_n)
	);

	sd_card_model sd_card_model_inst (
		.sd_clk     (sd_clk),
		.sd_cs      (sd_cs),
		.sd_mosi    (sd_mosi),
		.sd_miso    (sd_miso),
		.errors     (card_errors),
		.init_ok    (card_init_ok),
		.reads_done (card_reads)
	);

	model_loader_top model_loader_top_inst (
		.clk_osc             (clk_osc),
		.arst_n              (arst_n),
		.init_calib_complete (init_calib_complete),
		.app_rdy             (app_rdy),
		.app_wdf_rdy         (app_wdf_rdy),
		.sd_miso             (sd_miso),
		.app_wr              (app_wr),
		.sd_clk              (sd_clk),
		.sd_cs               (sd_cs),
		.sd_mosi             (sd_mosi),
		.led                 (led)
	);

	// expected word n holds payload bytes 16n to 16n+15 little endian
	function automatic logic [`APP_DATA_WIDTH-1:0] expected_word(input int n);
		logic [`APP_DATA_WIDTH-1:0] w;
		int                         k;
		for (k = 0; k < BPW; k++) begin
			w[8*k +: 8] = sd_card_model_inst.sector_mem[n * BPW + k];
		end
		return w;
	endfunction

	task automatic check_write();
		logic [`APP_ADDR_WIDTH-1:0] exp_addr;
		logic [`APP_DATA_WIDTH-1:0] exp_data;
		assert (words_seen < WORDS) else begin
			$display("write port transferred an extra word at address %h", app_wr.addr);
			write_errors++;
		end
		if (words_seen < WORDS) begin
			exp_addr = `APP_ADDR_WIDTH'(`APP_BASE_ADDR + words_seen * `APP_ADDR_STEP);
			exp_data = expected_word(words_seen);
			assert (app_wr.addr === exp_addr && app_wr.data === exp_data) else begin
				$display("Error word %0d: expected %h/%h, actual %h/%h", words_seen,
					exp_addr, exp_data, app_wr.addr, app_wr.data);
				write_errors++;
			end
		end
		assert (led[0] === 1'b1) else begin
			$display("Error card ready led: expected 1, actual %b", led[0]);
			write_errors++;
		end
		words_seen++;
	endtask

	task automatic print_counts();
		$display("error counts: gating %0d, write %0d, end %0d, card %0d",
			gate_errors, write_errors, end_errors, card_errors);
	endtask

	// random readies redrawn on every rising edge
	always @(posedge clk_osc) begin
		if (arst_n) begin
			app_rdy <= ($urandom_range(0, 99) >= STALL_PCT);
			app_wdf_rdy <= ($urandom_range(0, 99) >= STALL_PCT);
		end
	end

	// outputs sampled mid cycle where the readies hold what the next edge sees
	always @(negedge clk_osc) begin
		if (!init_calib_complete) begin
			assert (sd_cs === 1'b1 && sd_clk === 1'b0 && app_wr.en === 1'b0 && led === 2'b00)
			else begin
				$display("SD pins, write enable or LEDs active before calibration");
				gate_errors++;
			end
		end
		if (hold_pending) begin
			assert (app_wr.en === 1'b1 && app_wr.addr === held.addr && app_wr.data === held.data)
			else begin
				$display("Error hold: expected 1/%h/%h, actual %b/%h/%h", held.addr, held.data,
					app_wr.en, app_wr.addr, app_wr.data);
				write_errors++;
			end
		end
		if (led[1] === 1'b1) begin
			if (!done_seen) begin
				assert (words_seen == WORDS) else begin
					$display("Error load done: expected %0d words, actual %0d", WORDS, words_seen);
					end_errors++;
				end
			end
			done_seen = 1'b1;
			assert (app_wr.en === 1'b0 && sd_clk === 1'b0 && sd_cs === 1'b1) else begin
				$display("write port or SD pins active after load done");
				end_errors++;
			end
		end
		hold_pending = app_wr.en && !(app_rdy && app_wdf_rdy);
		held = app_wr;
		if (app_wr.en === 1'b1 && app_rdy && app_wdf_rdy) begin
			check_write();
		end
	end

	initial begin
		void'($urandom(SEED));
		init_calib_complete = 1'b0;
		app_rdy = 1'b0;
		app_wdf_rdy = 1'b0;
		hold_pending = 1'b0;
		done_seen = 1'b0;
		words_seen = 0;
		gate_errors = 0;
		write_errors = 0;
		end_errors = 0;
		wait (arst_n === 1'b1);
		// memory calibration finishes after a random delay
		repeat ($urandom_range(5, CALIB_MAX)) @(posedge clk_osc);
		init_calib_complete <= 1'b1;
		wait (led[1] === 1'b1);
		// quiet window in which the monitor flags any late activity
		repeat (QUIET_CYCLES) @(posedge clk_osc);
		assert (words_seen == WORDS) else begin
			$display("Error word count: expected %0d, actual %0d", WORDS, words_seen);
			end_errors++;
		end
		assert (card_reads == `SECTOR_COUNT) else begin
			$display("Error sector reads: expected %0d, actual %0d", `SECTOR_COUNT, card_reads);
			end_errors++;
		end
		assert (led === 2'b11) else begin
			$display("Error leds: expected 11, actual %b", led);
			end_errors++;
		end
		assert (card_init_ok) else begin
			$display("card model never answered the end of initialization");
			end_errors++;
		end
		print_counts();
		if (gate_errors + write_errors + end_errors + card_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// watchdog limit from sd byte time and the worst stall rate
	initial begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		$display("watchdog expired, load did not finish within %0d cycles", LIMIT_CYCLES);
		print_counts();
		$display("Checks failed");
		$finish;
	end

endmodule

/* project.f */
+incdir+include
hw/sd_pkg.sv
hw/mem_pkg.sv
hw/sd_spi_byte.sv
hw/sd_card_ctrl.sv
hw/app_write_packer.sv
hw/model_loader_top.sv
verification/tb_clock_gen.sv
verification/sd_card_model.sv
verification/tb_model_loader.sv

/* Bender.yml */
package:
  name: model_loader

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/sd_pkg.sv
      - hw/mem_pkg.sv
      - hw/sd_spi_byte.sv
      - hw/sd_card_ctrl.sv
      - hw/app_write_packer.sv
      - hw/model_loader_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/tb_clock_gen.sv
      - verification/sd_card_model.sv
      - verification/tb_model_loader.sv
